//--- rtl/exec_pkg.sv
package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  alu_op_t;
    typedef logic [5:0]  exc_code_t;
    typedef logic [3:0]  wstrb_t;

    localparam alu_op_t ALU_NOP  = 5'd0;
    localparam alu_op_t ALU_ADD  = 5'd1;
    localparam alu_op_t ALU_SUB  = 5'd2;
    localparam alu_op_t ALU_AND  = 5'd3;
    localparam alu_op_t ALU_OR   = 5'd4;
    localparam alu_op_t ALU_XOR  = 5'd5;
    localparam alu_op_t ALU_SLL  = 5'd6;
    localparam alu_op_t ALU_SRL  = 5'd7;
    localparam alu_op_t ALU_SRA  = 5'd8;
    localparam alu_op_t ALU_SLT  = 5'd9;
    localparam alu_op_t ALU_SLTU = 5'd10;
    localparam alu_op_t ALU_LUI  = 5'd11;
    // branches and jumps
    localparam alu_op_t ALU_BEQ  = 5'd12;
    localparam alu_op_t ALU_BNE  = 5'd13;
    localparam alu_op_t ALU_BLT  = 5'd14;
    localparam alu_op_t ALU_BLTU = 5'd15;
    localparam alu_op_t ALU_B    = 5'd16;
    localparam alu_op_t ALU_BL   = 5'd17;
    localparam alu_op_t ALU_JIRL = 5'd18;
    // loads and stores
    localparam alu_op_t ALU_LD_W = 5'd19;
    localparam alu_op_t ALU_LD_B = 5'd20;
    localparam alu_op_t ALU_ST_W = 5'd21;
    localparam alu_op_t ALU_ST_B = 5'd22;

    localparam exc_code_t EXC_NONE = 6'h00;
    localparam exc_code_t EXC_ALE  = 6'h09;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_t   alu_op;
        word_t     src_a;
        word_t     src_b;
        word_t     imm;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
    } issue_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        alu_op_t   alu_op;
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        word_t     reg_write_data;
        word_t     mem_addr;
        exc_code_t excp;
    } ex_result_t;

    typedef struct packed {
        logic      reg_write_en;
        reg_addr_t reg_write_addr;
        word_t     reg_write_data;
    } fwd_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  taken;
        word_t target;
    } branch_update_t;

    typedef struct packed {
        logic   valid;
        logic   is_store;
        word_t  addr;
        word_t  wdata;
        wstrb_t wstrb;
    } dcache_req_t;

endpackage

//--- rtl/branch_resolve.sv
module branch_resolve (
    input  exec_pkg::alu_op_t        alu_op_i,
    input  exec_pkg::word_t          pc_i,
    input  exec_pkg::word_t          src_a_i,
    input  exec_pkg::word_t          src_b_i,
    input  exec_pkg::word_t          imm_i,
    output logic                     taken_o,
    output exec_pkg::word_t          target_o,
    output exec_pkg::word_t          link_o,
    output exec_pkg::branch_update_t update_o
);

    logic is_branch;

    always_comb begin
        is_branch = 1'b1;
        taken_o   = 1'b0;
        case (alu_op_i)
            exec_pkg::ALU_BEQ:  taken_o = (src_a_i == src_b_i);
            exec_pkg::ALU_BNE:  taken_o = (src_a_i != src_b_i);
            exec_pkg::ALU_BLT:  taken_o = ($signed(src_a_i) < $signed(src_b_i));
            exec_pkg::ALU_BLTU: taken_o = (src_a_i < src_b_i);
            exec_pkg::ALU_B,
            exec_pkg::ALU_BL,
            exec_pkg::ALU_JIRL: taken_o = 1'b1;
            default:            is_branch = 1'b0;
        endcase
    end

    // jirl is register relative, the rest pc relative
    assign target_o = (alu_op_i == exec_pkg::ALU_JIRL) ? src_a_i + imm_i : pc_i + imm_i;
    assign link_o   = pc_i + 32'd4;

    always_comb begin
        update_o = '0;
        if (is_branch) begin
            update_o.valid  = 1'b1;
            update_o.pc     = pc_i;
            update_o.taken  = taken_o;
            update_o.target = target_o;
        end
    end

endmodule

//--- rtl/lsu_request.sv
module lsu_request (
    input  logic                  valid_i,
    input  exec_pkg::alu_op_t     alu_op_i,
    input  exec_pkg::word_t       src_a_i,
    input  exec_pkg::word_t       src_b_i,
    input  exec_pkg::word_t       imm_i,
    output exec_pkg::dcache_req_t req_o,
    output exec_pkg::exc_code_t   excp_o
);

    exec_pkg::word_t addr;
    logic            is_mem;
    logic            is_word;
    logic            is_store;
    logic            misaligned;

    assign addr     = src_a_i + imm_i;
    assign is_word  = (alu_op_i == exec_pkg::ALU_LD_W) || (alu_op_i == exec_pkg::ALU_ST_W);
    assign is_store = (alu_op_i == exec_pkg::ALU_ST_W) || (alu_op_i == exec_pkg::ALU_ST_B);
    assign is_mem   = valid_i && (is_word || is_store || alu_op_i == exec_pkg::ALU_LD_B);

    assign misaligned = is_mem && is_word && (addr[1:0] != 2'b00);
    assign excp_o     = misaligned ? exec_pkg::EXC_ALE : exec_pkg::EXC_NONE;

    // fields stay visible on a misaligned access, only valid drops
    always_comb begin
        req_o = '0;
        if (is_mem) begin
            req_o.valid    = !misaligned;
            req_o.is_store = is_store;
            req_o.addr     = addr;
            if (alu_op_i == exec_pkg::ALU_ST_B) begin
                req_o.wdata = {4{src_b_i[7:0]}};
                req_o.wstrb = 4'b0001 << addr[1:0];
            end else if (alu_op_i == exec_pkg::ALU_ST_W) begin
                req_o.wdata = src_b_i;
                req_o.wstrb = 4'b1111;
            end
        end
    end

endmodule

//--- rtl/exec_lane.sv
module exec_lane (
    input  exec_pkg::issue_t         issue_i,
    input  logic                     addr_ok_i,
    output exec_pkg::ex_result_t     result_o,
    output exec_pkg::dcache_req_t    dcache_req_o,
    output logic                     stall_o,
    output logic                     taken_o,
    output exec_pkg::word_t          target_o,
    output exec_pkg::branch_update_t update_o
);

    logic                     br_taken;
    exec_pkg::word_t          br_target;
    exec_pkg::word_t          br_link;
    exec_pkg::branch_update_t br_update;
    exec_pkg::exc_code_t      lsu_excp;
    exec_pkg::word_t          alu_out;

    branch_resolve branch_resolve_inst (
        .alu_op_i (issue_i.alu_op),
        .pc_i     (issue_i.pc),
        .src_a_i  (issue_i.src_a),
        .src_b_i  (issue_i.src_b),
        .imm_i    (issue_i.imm),
        .taken_o  (br_taken),
        .target_o (br_target),
        .link_o   (br_link),
        .update_o (br_update)
    );

    lsu_request lsu_request_inst (
        .valid_i  (issue_i.valid),
        .alu_op_i (issue_i.alu_op),
        .src_a_i  (issue_i.src_a),
        .src_b_i  (issue_i.src_b),
        .imm_i    (issue_i.imm),
        .req_o    (dcache_req_o),
        .excp_o   (lsu_excp)
    );

    always_comb begin
        case (issue_i.alu_op)
            exec_pkg::ALU_ADD:  alu_out = issue_i.src_a + issue_i.src_b;
            exec_pkg::ALU_SUB:  alu_out = issue_i.src_a - issue_i.src_b;
            exec_pkg::ALU_AND:  alu_out = issue_i.src_a & issue_i.src_b;
            exec_pkg::ALU_OR:   alu_out = issue_i.src_a | issue_i.src_b;
            exec_pkg::ALU_XOR:  alu_out = issue_i.src_a ^ issue_i.src_b;
            exec_pkg::ALU_SLL:  alu_out = issue_i.src_a << issue_i.src_b[4:0];
            exec_pkg::ALU_SRL:  alu_out = issue_i.src_a >> issue_i.src_b[4:0];
            exec_pkg::ALU_SRA:  alu_out = $signed(issue_i.src_a) >>> issue_i.src_b[4:0];
            exec_pkg::ALU_SLT:  alu_out = {31'b0, $signed(issue_i.src_a) < $signed(issue_i.src_b)};
            exec_pkg::ALU_SLTU: alu_out = {31'b0, issue_i.src_a < issue_i.src_b};
            exec_pkg::ALU_LUI:  alu_out = issue_i.imm;
            exec_pkg::ALU_BL,
            exec_pkg::ALU_JIRL: alu_out = br_link;
            // loads carry the address, aligned later in mem
            exec_pkg::ALU_LD_W,
            exec_pkg::ALU_LD_B: alu_out = dcache_req_o.addr;
            default:            alu_out = '0;
        endcase
    end

    always_comb begin
        result_o = '0;
        if (issue_i.valid) begin
            result_o.valid          = 1'b1;
            result_o.pc             = issue_i.pc;
            result_o.alu_op         = issue_i.alu_op;
            result_o.reg_write_en   = issue_i.reg_write_en;
            result_o.reg_write_addr = issue_i.reg_write_addr;
            result_o.reg_write_data = alu_out;
            result_o.mem_addr       = dcache_req_o.addr;
            result_o.excp           = lsu_excp;
        end
    end

    assign stall_o  = dcache_req_o.valid && !addr_ok_i;
    assign taken_o  = issue_i.valid && br_taken;
    assign target_o = taken_o ? br_target : '0;
    assign update_o = issue_i.valid ? br_update : '0;

endmodule

//--- rtl/exec_stage.sv
module exec_stage #(
    parameter int ISSUE_WIDTH = 2
) (
    input  logic                                      clk,
    input  logic                                      rst_n_i,

    input  logic                                      flush_i,
    input  logic                                      pause_i,

    input  exec_pkg::issue_t [ISSUE_WIDTH-1:0]        issue_i,

    output exec_pkg::dcache_req_t                     dcache_req_o,
    input  logic                                      dcache_addr_ok_i,

    output exec_pkg::fwd_t [ISSUE_WIDTH-1:0]          fwd_o,

    output logic                                      pause_ex_o,
    output logic                                      branch_flush_o,
    output exec_pkg::word_t                           branch_target_o,
    output logic                                      excp_flush_o,
    output exec_pkg::branch_update_t                  bpu_update_o,

    output exec_pkg::ex_result_t [ISSUE_WIDTH-1:0]    mem_o
);

    exec_pkg::ex_result_t     [ISSUE_WIDTH-1:0] lane_result;
    exec_pkg::dcache_req_t    [ISSUE_WIDTH-1:0] lane_req;
    exec_pkg::word_t          [ISSUE_WIDTH-1:0] lane_target;
    exec_pkg::branch_update_t [ISSUE_WIDTH-1:0] lane_update;
    logic                     [ISSUE_WIDTH-1:0] lane_stall;
    logic                     [ISSUE_WIDTH-1:0] lane_taken;
    logic                     [ISSUE_WIDTH-1:0] lane_excp;
    logic                     [ISSUE_WIDTH-1:0] keep;

    for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_lane
        exec_lane exec_lane_inst (
            .issue_i      (issue_i[i]),
            .addr_ok_i    (dcache_addr_ok_i),
            .result_o     (lane_result[i]),
            .dcache_req_o (lane_req[i]),
            .stall_o      (lane_stall[i]),
            .taken_o      (lane_taken[i]),
            .target_o     (lane_target[i]),
            .update_o     (lane_update[i])
        );

        assign lane_excp[i] = lane_result[i].valid
                              && (lane_result[i].excp != exec_pkg::EXC_NONE);

        assign fwd_o[i].reg_write_en   = lane_result[i].reg_write_en;
        assign fwd_o[i].reg_write_addr = lane_result[i].reg_write_addr;
        assign fwd_o[i].reg_write_data = lane_result[i].reg_write_data;
    end

    // walk down so the oldest lane wins
    always_comb begin
        dcache_req_o = '0;
        for (int i = ISSUE_WIDTH - 1; i >= 0; i--) begin
            if (lane_req[i].valid) begin
                dcache_req_o = lane_req[i];
            end
        end
    end

    always_comb begin
        branch_target_o = '0;
        bpu_update_o    = '0;
        for (int i = ISSUE_WIDTH - 1; i >= 0; i--) begin
            if (lane_taken[i]) begin
                branch_target_o = lane_target[i];
                bpu_update_o    = lane_update[i];
            end
        end
    end

    // lanes behind the first taken branch are wrong path
    always_comb begin
        keep[0] = 1'b1;
        for (int i = 1; i < ISSUE_WIDTH; i++) begin
            keep[i] = keep[i-1] && !lane_taken[i-1];
        end
    end

    assign pause_ex_o     = |lane_stall;
    assign branch_flush_o = |lane_taken && !pause_ex_o;
    assign excp_flush_o   = |lane_excp && !pause_ex_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mem_o <= '0;
        end else if (flush_i || pause_ex_o) begin
            // bubble
            mem_o <= '0;
        end else if (!pause_i) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                mem_o[i] <= keep[i] ? lane_result[i] : '0;
            end
        end
    end

endmodule

//--- test/tb_clock.sv
module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #2 clk_o = ~clk_o;
    end

    // released on a falling edge, away from the register edge
    initial begin
        rst_n_o = 1'b0;
        repeat (16) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end
endmodule

//--- test/exec_stage_tb.sv
module exec_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 50;

    logic                               clk;
    logic                               rst_n;
    logic                               flush;
    logic                               pause;
    logic                               addr_ok;
    exec_pkg::issue_t [1:0]             issue;
    exec_pkg::dcache_req_t              dcache_req;
    exec_pkg::fwd_t [1:0]               fwd;
    logic                               pause_ex;
    logic                               branch_flush;
    exec_pkg::word_t                    branch_target;
    logic                               excp_flush;
    exec_pkg::branch_update_t           bpu_update;
    exec_pkg::ex_result_t [1:0]         mem_out;
    int                                 errors;

    tb_clock tb_clock_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    exec_stage #(.ISSUE_WIDTH(2)) exec_stage_inst (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .flush_i          (flush),
        .pause_i          (pause),
        .issue_i          (issue),
        .dcache_req_o     (dcache_req),
        .dcache_addr_ok_i (addr_ok),
        .fwd_o            (fwd),
        .pause_ex_o       (pause_ex),
        .branch_flush_o   (branch_flush),
        .branch_target_o  (branch_target),
        .excp_flush_o     (excp_flush),
        .bpu_update_o     (bpu_update),
        .mem_o            (mem_out)
    );

    function automatic exec_pkg::issue_t make_op(input exec_pkg::alu_op_t op,
                                                 input exec_pkg::word_t a, b, imm);
        exec_pkg::issue_t u;
        u                = '0;
        u.valid          = 1'b1;
        u.pc             = $urandom & 32'hffff_fffc;
        u.alu_op         = op;
        u.src_a          = a;
        u.src_b          = b;
        u.imm            = imm;
        u.reg_write_en   = 1'b1;
        u.reg_write_addr = exec_pkg::reg_addr_t'($urandom_range(31, 1));
        return u;
    endfunction

    // expected lane result
    function automatic exec_pkg::ex_result_t expect_result(input exec_pkg::issue_t u);
        exec_pkg::ex_result_t r;
        exec_pkg::word_t      addr;
        logic                 is_mem;
        logic                 is_word;
        r       = '0;
        addr    = u.src_a + u.imm;
        is_mem  = u.alu_op inside {exec_pkg::ALU_LD_W, exec_pkg::ALU_LD_B,
                                   exec_pkg::ALU_ST_W, exec_pkg::ALU_ST_B};
        is_word = u.alu_op inside {exec_pkg::ALU_LD_W, exec_pkg::ALU_ST_W};
        if (!u.valid) begin
            return r;
        end
        r.valid          = 1'b1;
        r.pc             = u.pc;
        r.alu_op         = u.alu_op;
        r.reg_write_en   = u.reg_write_en;
        r.reg_write_addr = u.reg_write_addr;
        r.mem_addr       = is_mem ? addr : '0;
        if (is_word && addr[1:0] != 2'b00) begin
            r.excp = exec_pkg::EXC_ALE;
        end
        case (u.alu_op)
            exec_pkg::ALU_ADD:  r.reg_write_data = u.src_a + u.src_b;
            exec_pkg::ALU_SUB:  r.reg_write_data = u.src_a - u.src_b;
            exec_pkg::ALU_AND:  r.reg_write_data = u.src_a & u.src_b;
            exec_pkg::ALU_OR:   r.reg_write_data = u.src_a | u.src_b;
            exec_pkg::ALU_XOR:  r.reg_write_data = u.src_a ^ u.src_b;
            exec_pkg::ALU_SLL:  r.reg_write_data = u.src_a << u.src_b[4:0];
            exec_pkg::ALU_SRL:  r.reg_write_data = u.src_a >> u.src_b[4:0];
            exec_pkg::ALU_SRA:  r.reg_write_data = $signed(u.src_a) >>> u.src_b[4:0];
            exec_pkg::ALU_SLT:  r.reg_write_data = ($signed(u.src_a) < $signed(u.src_b)) ? 1 : 0;
            exec_pkg::ALU_SLTU: r.reg_write_data = (u.src_a < u.src_b) ? 32'd1 : 32'd0;
            exec_pkg::ALU_LUI:  r.reg_write_data = u.imm;
            exec_pkg::ALU_BL,
            exec_pkg::ALU_JIRL: r.reg_write_data = u.pc + 32'd4;
            exec_pkg::ALU_LD_W,
            exec_pkg::ALU_LD_B: r.reg_write_data = addr;
            default:            r.reg_write_data = '0;
        endcase
        return r;
    endfunction

    // forwarding mirrors the write-back part of a lane result
    function automatic exec_pkg::fwd_t expect_fwd(input exec_pkg::ex_result_t r);
        exec_pkg::fwd_t f;
        f.reg_write_en   = r.reg_write_en;
        f.reg_write_addr = r.reg_write_addr;
        f.reg_write_data = r.reg_write_data;
        return f;
    endfunction

    // aligned memory ops only
    function automatic exec_pkg::dcache_req_t expect_req(input exec_pkg::issue_t u);
        exec_pkg::dcache_req_t q;
        q          = '0;
        q.valid    = 1'b1;
        q.addr     = u.src_a + u.imm;
        q.is_store = u.alu_op inside {exec_pkg::ALU_ST_W, exec_pkg::ALU_ST_B};
        if (u.alu_op == exec_pkg::ALU_ST_W) begin
            q.wdata = u.src_b;
            q.wstrb = 4'b1111;
        end else if (u.alu_op == exec_pkg::ALU_ST_B) begin
            q.wdata = {4{u.src_b[7:0]}};
            q.wstrb = 4'b0001 << q.addr[1:0];
        end
        return q;
    endfunction

    task automatic check_result(input string name, input exec_pkg::ex_result_t exp, act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_req(input string name, input exec_pkg::dcache_req_t exp, act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_fwd(input string name, input exec_pkg::fwd_t exp, act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input exec_pkg::word_t exp, act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, act);
        if (act !== exp) begin
            errors++;
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        #1;
    endtask

    task automatic apply(input exec_pkg::issue_t l0, l1);
        @(negedge clk);
        issue[0] = l0;
        issue[1] = l1;
        #1;
    endtask

    // one clock later the ex/mem register shows the pair
    task automatic check_mem(input string name, input exec_pkg::ex_result_t e0, e1);
        next_cycle();
        check_result({name, " mem lane0"}, e0, mem_out[0]);
        check_result({name, " mem lane1"}, e1, mem_out[1]);
    endtask

    task automatic test_reset();
        int t;
        t = 0;
        while (rst_n !== 1'b1 && t < TIMEOUT) begin
            @(negedge clk);
            t++;
        end
        if (rst_n !== 1'b1) begin
            errors++;
            $display("timeout: reset was never released");
        end
        next_cycle();
        check_result("reset mem lane0", '0, mem_out[0]);
        check_result("reset mem lane1", '0, mem_out[1]);
        check_bit("reset pause_ex", 1'b0, pause_ex);
        check_bit("reset branch_flush", 1'b0, branch_flush);
        check_bit("reset excp_flush", 1'b0, excp_flush);
        check_req("reset dcache_req", '0, dcache_req);
        check_word("reset branch_target", '0, branch_target);
    endtask

    task automatic test_alu();
        exec_pkg::issue_t     l0;
        exec_pkg::issue_t     l1;
        exec_pkg::ex_result_t e0;
        exec_pkg::ex_result_t e1;
        for (exec_pkg::alu_op_t op = exec_pkg::ALU_ADD; op <= exec_pkg::ALU_LUI; op++) begin
            l0 = make_op(op, $urandom, $urandom, $urandom);
            l1 = make_op(op, $urandom, $urandom, $urandom);
            e0 = expect_result(l0);
            e1 = expect_result(l1);
            apply(l0, l1);
            check_fwd($sformatf("alu op %0d fwd lane0", op), expect_fwd(e0), fwd[0]);
            check_fwd($sformatf("alu op %0d fwd lane1", op), expect_fwd(e1), fwd[1]);
            check_mem($sformatf("alu op %0d", op), e0, e1);
        end
    endtask

    task automatic test_branch();
        exec_pkg::issue_t l0;
        exec_pkg::issue_t l1;
        exec_pkg::word_t  a;
        a  = $urandom;
        // lane 1 is on the wrong path
        l0 = make_op(exec_pkg::ALU_BEQ, a, a, 32'h40);
        l1 = make_op(exec_pkg::ALU_ADD, $urandom, $urandom, '0);
        apply(l0, l1);
        check_bit("beq flush", 1'b1, branch_flush);
        check_word("beq target", l0.pc + 32'h40, branch_target);
        check_bit("beq update valid", 1'b1, bpu_update.valid);
        check_bit("beq update taken", 1'b1, bpu_update.taken);
        check_word("beq update pc", l0.pc, bpu_update.pc);
        check_word("beq update target", l0.pc + 32'h40, bpu_update.target);
        check_mem("beq", expect_result(l0), '0);
        l0 = make_op(exec_pkg::ALU_ADD, $urandom, $urandom, '0);
        l1 = make_op(exec_pkg::ALU_BNE, a, ~a, 32'hffff_fff8);
        apply(l0, l1);
        check_bit("bne flush", 1'b1, branch_flush);
        check_word("bne target", l1.pc + 32'hffff_fff8, branch_target);
        check_mem("bne", expect_result(l0), expect_result(l1));
        l0 = make_op(exec_pkg::ALU_BLT, 32'd5, 32'hffff_fffb, 32'h10);
        l1 = make_op(exec_pkg::ALU_BLTU, 32'hffff_fff0, 32'd1, 32'h10);
        apply(l0, l1);
        check_bit("untaken flush", 1'b0, branch_flush);
        check_word("untaken target", '0, branch_target);
        check_bit("untaken update valid", 1'b0, bpu_update.valid);
        check_mem("untaken", expect_result(l0), expect_result(l1));
        l0 = make_op(exec_pkg::ALU_BL, $urandom, $urandom, 32'h100);
        apply(l0, '0);
        check_word("bl link", l0.pc + 32'd4, fwd[0].reg_write_data);
        check_mem("bl", expect_result(l0), '0);
        l0 = make_op(exec_pkg::ALU_ADD, $urandom, $urandom, '0);
        l1 = make_op(exec_pkg::ALU_JIRL, a, $urandom, 32'h20);
        apply(l0, l1);
        check_word("jirl target", a + 32'h20, branch_target);
        check_word("jirl link", l1.pc + 32'd4, fwd[1].reg_write_data);
        check_mem("jirl", expect_result(l0), expect_result(l1));
    endtask

    task automatic wait_pause_clear();
        int t;
        t = 0;
        while (pause_ex && t < TIMEOUT) begin
            next_cycle();
            t++;
        end
        if (pause_ex) begin
            errors++;
            $display("timeout: pause_ex_o stayed high after addr_ok returned");
        end
    endtask

    task automatic test_mem_request();
        exec_pkg::issue_t l0;
        exec_pkg::issue_t l1;
        exec_pkg::word_t  base;
        base = $urandom & 32'hffff_fff0;
        l0   = make_op(exec_pkg::ALU_ST_W, base, $urandom, 32'h8);
        apply(l0, '0);
        check_req("st_w request", expect_req(l0), dcache_req);
        check_mem("st_w", expect_result(l0), '0);
        // store from the younger lane
        l0 = make_op(exec_pkg::ALU_ADD, $urandom, $urandom, '0);
        l1 = make_op(exec_pkg::ALU_ST_B, base, $urandom, 32'h6);
        apply(l0, l1);
        check_req("st_b request", expect_req(l1), dcache_req);
        check_mem("st_b", expect_result(l0), expect_result(l1));
        l0 = make_op(exec_pkg::ALU_LD_B, base, $urandom, 32'h3);
        apply(l0, '0);
        check_req("ld_b request", expect_req(l0), dcache_req);
        check_mem("ld_b", expect_result(l0), '0);
        // cache not ready
        l0 = make_op(exec_pkg::ALU_LD_W, base, $urandom, 32'h4);
        @(negedge clk);
        issue[0] = l0;
        issue[1] = '0;
        addr_ok  = 1'b0;
        #1;
        check_req("ld_w stalled request", expect_req(l0), dcache_req);
        repeat (3) begin
            check_bit("ld_w stalled pause_ex", 1'b1, pause_ex);
            check_mem("ld_w stalled bubble", '0, '0);
        end
        @(negedge clk);
        addr_ok = 1'b1;
        #1;
        wait_pause_clear();
        check_mem("ld_w accepted", expect_result(l0), '0);
    endtask

    task automatic test_misaligned();
        exec_pkg::issue_t l0;
        l0 = make_op(exec_pkg::ALU_LD_W, $urandom & 32'hffff_fffc, $urandom, 32'h5);
        apply(l0, '0);
        check_bit("misaligned excp_flush", 1'b1, excp_flush);
        check_bit("misaligned request valid", 1'b0, dcache_req.valid);
        check_bit("misaligned pause_ex", 1'b0, pause_ex);
        check_mem("misaligned", expect_result(l0), '0);
    endtask

    task automatic test_flush_pause();
        exec_pkg::issue_t a0;
        exec_pkg::issue_t a1;
        exec_pkg::issue_t b0;
        exec_pkg::issue_t b1;
        a0 = make_op(exec_pkg::ALU_ADD, $urandom, $urandom, '0);
        a1 = make_op(exec_pkg::ALU_XOR, $urandom, $urandom, '0);
        b0 = make_op(exec_pkg::ALU_SUB, $urandom, $urandom, '0);
        b1 = make_op(exec_pkg::ALU_OR, $urandom, $urandom, '0);
        apply(a0, a1);
        check_mem("flush setup", expect_result(a0), expect_result(a1));
        @(negedge clk);
        flush = 1'b1;
        check_mem("flush", '0, '0);
        @(negedge clk);
        flush = 1'b0;
        check_mem("after flush", expect_result(a0), expect_result(a1));
        // new pair arrives while paused
        @(negedge clk);
        pause    = 1'b1;
        issue[0] = b0;
        issue[1] = b1;
        check_mem("pause hold", expect_result(a0), expect_result(a1));
        check_mem("pause hold again", expect_result(a0), expect_result(a1));
        @(negedge clk);
        pause = 1'b0;
        check_mem("pause release", expect_result(b0), expect_result(b1));
    endtask

    initial begin
        void'($urandom(32'ha2441d0e));
        errors  = 0;
        flush   = 1'b0;
        pause   = 1'b0;
        addr_ok = 1'b1;
        issue   = '0;
        test_reset();
        test_alu();
        test_branch();
        test_mem_request();
        test_misaligned();
        test_flush_pause();
        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end
endmodule

//--- build.f
rtl/exec_pkg.sv
rtl/branch_resolve.sv
rtl/lsu_request.sv
rtl/exec_lane.sv
rtl/exec_stage.sv
test/tb_clock.sv
test/exec_stage_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f build.f \
    --top-module exec_stage_tb -o exec_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/exec_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1
